// ==== verification/pe_input.txt ====
// columns: kind count packet, all hex; kind 1 send, 2 expect, 3 reset, 0 end
// send: count nonzero means that many output packets seen at in_ack; expect: first out_dat
1 00 7001008040201
1 00 107000001ABCDEF
2 15 7E00000000000F
1 00 10700000155AA55
2 15 7E00000002A015
3 00 0
1 00 107000001ABCDEF
1 00 7001008040201
2 15 7E00000000000F
1 00 107000000F0F0F3
1 15 7007FC43380FF
2 15 7E00000002A013
1 00 107000000A5C3E1
2 15 7E0000000140FF
0 00 0

// ==== all.f ====
design/noc_pkg.sv
design/pe_pkg.sv
design/packet_rx.sv
design/operand_store.sv
design/conv_sequencer.sv
design/mac_unit.sv
design/psum_tx.sv
design/pe_top.sv
verification/pe_properties.sv
verification/pe_tb.sv

// ==== Makefile ====
SOURCES := $(wildcard design/*.sv verification/*.sv)

.PHONY: run clean

run: obj_dir/Vpe_tb
	./obj_dir/Vpe_tb > sim.log 2>&1 || true
	cat sim.log
	grep -q "Simulation completed successfully" sim.log

obj_dir/Vpe_tb: all.f $(SOURCES)
	verilator --binary --timing --assert --top-module pe_tb -f all.f -Mdir obj_dir -o Vpe_tb

clean:
	rm -rf obj_dir sim.log

// ==== verification/pe_tb.sv ====
`timescale 1ns/1ps

module pe_tb;

    localparam int PE_ID = 7;
    localparam int PSUM_DEPTH = 32;
    localparam int wait_limit = 3000;
    localparam int rec_words = 64;

    logic                 clk;
    logic                 rst;
    logic                 in_cyc;
    logic                 in_stb;
    logic                 in_we;
    noc_pkg::noc_packet_t in_dat;
    logic                 in_ack;
    logic                 out_cyc;
    logic                 out_stb;
    logic                 out_we;
    noc_pkg::noc_packet_t out_dat;
    logic                 out_ack;

    logic [56:0]          rec_mem [0:rec_words-1];
    noc_pkg::noc_packet_t rx_q[$];
    pe_pkg::psum_t        exp_q[$];
    logic [24:0]          model_ifmap;
    logic [4:0][7:0]      model_weights;
    logic                 model_ifmap_ok;
    logic                 model_filter_ok;
    int                   mismatch_count;
    int                   fail_count;

    pe_top #(
        .PE_ID      (PE_ID),
        .PSUM_DEPTH (PSUM_DEPTH)
    ) u_dut (
        .clk     (clk),
        .rst     (rst),
        .in_cyc  (in_cyc),
        .in_stb  (in_stb),
        .in_we   (in_we),
        .in_dat  (in_dat),
        .in_ack  (in_ack),
        .out_cyc (out_cyc),
        .out_stb (out_stb),
        .out_we  (out_we),
        .out_dat (out_dat),
        .out_ack (out_ack)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic compare(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            mismatch_count++;
            $display("mismatch %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic apply_reset();
        rst = 1'b1;
        rx_q.delete();
        exp_q.delete();
        model_ifmap_ok = 1'b0;
        model_filter_ok = 1'b0;
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;
    endtask

    // each sum adds weight k where activation i+k is set
    function automatic void load_model(input noc_pkg::noc_packet_t pkt);
        pe_pkg::psum_t sum;
        if (pkt.header.iff_type) begin
            model_ifmap = pkt.payload.ifmap.bits;
            model_ifmap_ok = 1'b1;
        end else begin
            model_weights = pkt.payload.filter;
            model_filter_ok = 1'b1;
        end
        if (model_ifmap_ok && model_filter_ok) begin
            for (int i = 0; i < pe_pkg::output_count; i++) begin
                sum = '0;
                for (int k = 0; k < pe_pkg::filter_depth; k++) begin
                    if (model_ifmap[i + k]) begin
                        sum = sum + 13'(model_weights[k]);
                    end
                end
                exp_q.push_back(sum);
            end
            // the filter stays and the ifmap is used up
            model_ifmap_ok = 1'b0;
        end
    endfunction

    task automatic send_packet(input noc_pkg::noc_packet_t pkt, input int seen_at_ack,
                               output bit ok);
        int waited;
        waited = 0;
        ok = 1'b0;
        in_cyc = 1'b1;
        in_stb = 1'b1;
        in_we = 1'b1;
        in_dat = pkt;
        while (!ok && waited < wait_limit) begin
            @(negedge clk);
            if (in_ack) begin
                ok = 1'b1;
            end else begin
                waited++;
            end
        end
        if (!ok) begin
            fail_count++;
            $display("timeout: inbound packet %h was never acknowledged", pkt);
        end else begin
            if (seen_at_ack != 0) begin
                compare("output count at in_ack", 64'(rx_q.size()), 64'(seen_at_ack));
            end
            load_model(pkt);
        end
        @(posedge clk);
        #1;
        in_cyc = 1'b0;
        in_stb = 1'b0;
        in_we = 1'b0;
    endtask

    task automatic expect_round(input int count, input noc_pkg::noc_packet_t first,
                                output bit ok);
        noc_pkg::noc_packet_t got_pkt;
        noc_pkg::noc_packet_t exp_pkt;
        int                   waited;
        int                   addr;
        waited = 0;
        while (rx_q.size() < count && waited < wait_limit) begin
            @(negedge clk);
            waited++;
        end
        ok = (rx_q.size() >= count);
        if (!ok) begin
            fail_count++;
            $display("timeout: only %0d of %0d output packets arrived", rx_q.size(), count);
        end else begin
            compare("out_dat of first packet", 64'(rx_q[0]), 64'(first));
            compare("expected sum count", 64'(exp_q.size()), 64'(count));
            addr = int'(first.payload.psum.addr);
            for (int i = 0; i < count; i++) begin
                got_pkt = rx_q.pop_front();
                exp_pkt = first;
                exp_pkt.payload.psum.addr = noc_pkg::psum_addr_w'((addr + i) % PSUM_DEPTH);
                if (exp_q.size() > 0) begin
                    exp_pkt.payload.psum.value = exp_q.pop_front();
                end
                compare("out_dat", 64'(got_pkt), 64'(exp_pkt));
            end
        end
        @(posedge clk);
        #1;
    endtask

    // outbound slave that acks each request after a random number of cycles
    initial begin
        void'($urandom(74230));
        out_ack = 1'b0;
        forever begin
            @(negedge clk);
            if (!rst && out_stb) begin
                repeat ($urandom % 4) @(posedge clk);
                @(posedge clk);
                #1;
                compare("out_cyc", 64'(out_cyc), 64'(1'b1));
                compare("out_we", 64'(out_we), 64'(1'b1));
                out_ack = 1'b1;
                rx_q.push_back(out_dat);
                @(posedge clk);
                #1;
                out_ack = 1'b0;
            end
        end
    end

    initial begin
        int idx;
        bit ok;
        bit running;
        in_cyc = 1'b0;
        in_stb = 1'b0;
        in_we = 1'b0;
        in_dat = '0;
        mismatch_count = 0;
        fail_count = 0;
        $readmemh("verification/pe_input.txt", rec_mem);
        apply_reset();
        idx = 0;
        running = 1'b1;
        // each record is three words of kind, count and packet
        while (running && idx + 2 < rec_words) begin
            ok = 1'b1;
            case (rec_mem[idx])
                57'd0: running = 1'b0;
                57'd1: send_packet(rec_mem[idx + 2], int'(rec_mem[idx + 1]), ok);
                57'd2: expect_round(int'(rec_mem[idx + 1]), rec_mem[idx + 2], ok);
                57'd3: apply_reset();
                default: begin
                    fail_count++;
                    $display("unknown record kind at word %0d of the input file", idx);
                    ok = 1'b0;
                end
            endcase
            if (!ok) begin
                running = 1'b0;
            end
            idx += 3;
        end
        repeat (5) @(posedge clk);
        $display("checks done: %0d mismatches, %0d other failures", mismatch_count, fail_count);
        if (mismatch_count == 0 && fail_count == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== verification/pe_properties.sv ====
`timescale 1ns/1ps

module pe_properties (
    input logic                 clk,
    input logic                 rst,
    input logic                 in_stb,
    input logic                 in_ack,
    input logic                 out_stb,
    input logic                 out_ack,
    input noc_pkg::noc_packet_t out_dat
);

    logic [2:0] since_rst;

    // cycles since reset was released, saturating at 5
    always_ff @(posedge clk) begin
        if (rst) begin
            since_rst <= 3'd0;
        end else if (since_rst != 3'd5) begin
            since_rst <= since_rst + 3'd1;
        end
    end

    ack_needs_stb: assert property (@(posedge clk) disable iff (rst) in_ack |-> in_stb)
        else $error("in_ack raised without in_stb");

    // request and data stay put until the slave answers
    stb_held: assert property (@(posedge clk) disable iff (rst)
        (out_stb && !out_ack) |=> (out_stb && $stable(out_dat)))
        else $error("out_stb or out_dat changed before out_ack");

    quiet_after_rst: assert property (@(posedge clk) (!rst && since_rst < 3'd5) |-> !out_stb)
        else $error("out_stb raised within 5 cycles of reset");

endmodule

bind pe_top pe_properties u_props (
    .clk     (clk),
    .rst     (rst),
    .in_stb  (in_stb),
    .in_ack  (in_ack),
    .out_stb (out_stb),
    .out_ack (out_ack),
    .out_dat (out_dat)
);

// ==== design/pe_top.sv ====
`timescale 1ns/1ps

module pe_top #(
    parameter int PE_ID = 1,
    parameter int PSUM_DEPTH = 441
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 in_cyc,
    input  logic                 in_stb,
    input  logic                 in_we,
    input  noc_pkg::noc_packet_t in_dat,
    output logic                 in_ack,
    output logic                 out_cyc,
    output logic                 out_stb,
    output logic                 out_we,
    output noc_pkg::noc_packet_t out_dat,
    input  logic                 out_ack
);

    logic                                       load_ifmap;
    logic                                       load_filter;
    logic [pe_pkg::ifmap_depth-1:0]             ifmap_bits;
    pe_pkg::weight_t [pe_pkg::filter_depth-1:0] filter_weights;
    logic                                       operands_ready;
    logic                                       ifmap_bit;
    pe_pkg::weight_t                            weight;
    pe_pkg::ifmap_addr_t                        ifmap_addr;
    pe_pkg::filter_addr_t                       filter_addr;
    logic                                       tap_valid;
    logic                                       acc_clear;
    logic                                       emit;
    logic                                       round_done;
    logic                                       compute_busy;
    logic                                       psum_valid;
    pe_pkg::psum_result_t                       psum;
    logic                                       tx_busy;

    packet_rx u_rx (
        .clk            (clk),
        .rst            (rst),
        .in_cyc         (in_cyc),
        .in_stb         (in_stb),
        .in_we          (in_we),
        .in_dat         (in_dat),
        .compute_busy   (compute_busy),
        .in_ack         (in_ack),
        .load_ifmap     (load_ifmap),
        .load_filter    (load_filter),
        .ifmap_bits     (ifmap_bits),
        .filter_weights (filter_weights)
    );

    operand_store u_store (
        .clk            (clk),
        .rst            (rst),
        .load_ifmap     (load_ifmap),
        .load_filter    (load_filter),
        .ifmap_bits     (ifmap_bits),
        .filter_weights (filter_weights),
        .ifmap_addr     (ifmap_addr),
        .filter_addr    (filter_addr),
        .round_done     (round_done),
        .operands_ready (operands_ready),
        .ifmap_bit      (ifmap_bit),
        .weight         (weight)
    );

    conv_sequencer u_seq (
        .clk            (clk),
        .rst            (rst),
        .operands_ready (operands_ready),
        .tx_busy        (tx_busy),
        .ifmap_addr     (ifmap_addr),
        .filter_addr    (filter_addr),
        .tap_valid      (tap_valid),
        .acc_clear      (acc_clear),
        .emit           (emit),
        .round_done     (round_done),
        .compute_busy   (compute_busy)
    );

    mac_unit u_mac (
        .clk        (clk),
        .rst        (rst),
        .tap_valid  (tap_valid),
        .acc_clear  (acc_clear),
        .emit       (emit),
        .ifmap_bit  (ifmap_bit),
        .weight     (weight),
        .psum_valid (psum_valid),
        .psum       (psum)
    );

    psum_tx #(
        .PE_ID      (PE_ID),
        .PSUM_DEPTH (PSUM_DEPTH)
    ) u_tx (
        .clk        (clk),
        .rst        (rst),
        .psum_valid (psum_valid),
        .psum       (psum),
        .out_ack    (out_ack),
        .tx_busy    (tx_busy),
        .out_cyc    (out_cyc),
        .out_stb    (out_stb),
        .out_we     (out_we),
        .out_dat    (out_dat)
    );

endmodule

// ==== design/psum_tx.sv ====
`timescale 1ns/1ps

module psum_tx #(
    parameter int PE_ID = 1,
    parameter int PSUM_DEPTH = 441
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 psum_valid,
    input  pe_pkg::psum_result_t psum,
    input  logic                 out_ack,
    output logic                 tx_busy,
    output logic                 out_cyc,
    output logic                 out_stb,
    output logic                 out_we,
    output noc_pkg::noc_packet_t out_dat
);

    localparam noc_pkg::node_id_t src_id = noc_pkg::node_id_t'(PE_ID);

    // PEs 1 to 5 report to the low collector
    localparam noc_pkg::node_id_t dest_id =
        (PE_ID >= 1 && PE_ID <= noc_pkg::last_low_pe) ?
        noc_pkg::collector_low : noc_pkg::collector_high;

    localparam logic [noc_pkg::psum_addr_w-1:0] last_addr =
        noc_pkg::psum_addr_w'(PSUM_DEPTH - 1);

    logic                            busy_q;
    pe_pkg::psum_t                   value_q;
    logic [noc_pkg::psum_addr_w-1:0] psum_addr;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy_q    <= 1'b0;
            psum_addr <= '0;
        end else if (busy_q) begin
            if (out_ack) begin
                busy_q    <= 1'b0;
                psum_addr <= (psum_addr == last_addr) ?
                             '0 : psum_addr + noc_pkg::psum_addr_w'(1);
            end
        end else if (psum_valid) begin
            busy_q <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (psum_valid && !busy_q) begin
            value_q <= psum.value;
        end
    end

    // routing fields go out as zero and the network fills them in
    always_comb begin
        out_dat                     = '0;
        out_dat.header.iff_type     = 1'b0;
        out_dat.header.source       = src_id;
        out_dat.header.dest         = dest_id;
        out_dat.payload.psum.addr   = psum_addr;
        out_dat.payload.psum.value  = value_q;
    end

    assign out_cyc = busy_q;
    assign out_stb = busy_q;
    assign out_we = busy_q;
    assign tx_busy = busy_q;

endmodule

// ==== design/mac_unit.sv ====
`timescale 1ns/1ps

module mac_unit (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 tap_valid,
    input  logic                 acc_clear,
    input  logic                 emit,
    input  logic                 ifmap_bit,
    input  pe_pkg::weight_t      weight,
    output logic                 psum_valid,
    output pe_pkg::psum_result_t psum
);

    pe_pkg::weight_t gated_q;
    logic            s1_valid;
    logic            s1_clear;
    logic            s1_emit;
    pe_pkg::psum_t   acc_q;

    // operand stage, a one-bit activation turns the multiply into a gate
    always_ff @(posedge clk) begin
        gated_q <= ifmap_bit ? weight : '0;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            s1_valid   <= 1'b0;
            s1_clear   <= 1'b0;
            s1_emit    <= 1'b0;
            psum_valid <= 1'b0;
        end else begin
            s1_valid   <= tap_valid;
            s1_clear   <= acc_clear;
            s1_emit    <= emit;
            psum_valid <= s1_valid & s1_emit;
        end
    end

    // accumulate stage
    always_ff @(posedge clk) begin
        if (s1_valid) begin
            if (s1_clear) begin
                acc_q <= pe_pkg::psum_t'(gated_q);
            end else begin
                acc_q <= acc_q + pe_pkg::psum_t'(gated_q);
            end
        end
    end

    assign psum.value = acc_q;

endmodule

// ==== design/conv_sequencer.sv ====
`timescale 1ns/1ps

module conv_sequencer (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 operands_ready,
    input  logic                 tx_busy,
    output pe_pkg::ifmap_addr_t  ifmap_addr,
    output pe_pkg::filter_addr_t filter_addr,
    output logic                 tap_valid,
    output logic                 acc_clear,
    output logic                 emit,
    output logic                 round_done,
    output logic                 compute_busy
);

    localparam logic [2:0] st_idle = 3'd0;
    localparam logic [2:0] st_run  = 3'd1;
    localparam logic [2:0] st_gap  = 3'd2;
    localparam logic [2:0] st_wait = 3'd3;
    localparam logic [2:0] st_done = 3'd4;

    localparam pe_pkg::filter_addr_t last_tap = pe_pkg::filter_addr_t'(pe_pkg::filter_depth - 1);
    localparam pe_pkg::ifmap_addr_t last_out = pe_pkg::ifmap_addr_t'(pe_pkg::output_count - 1);

    logic [2:0]           state;
    pe_pkg::ifmap_addr_t  out_idx;
    pe_pkg::filter_addr_t tap_idx;
    logic                 gap_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= st_idle;
            out_idx <= '0;
            tap_idx <= '0;
            gap_q   <= 1'b0;
        end else begin
            case (state)
                st_idle: begin
                    out_idx <= '0;
                    tap_idx <= '0;
                    if (operands_ready) begin
                        state <= st_run;
                    end
                end
                st_run: begin
                    if (tap_idx == last_tap) begin
                        tap_idx <= '0;
                        gap_q   <= 1'b0;
                        state   <= st_gap;
                    end else begin
                        tap_idx <= tap_idx + 3'd1;
                    end
                end
                // two cycles for the sum to reach psum_tx
                st_gap: begin
                    gap_q <= 1'b1;
                    if (gap_q) begin
                        state <= st_wait;
                    end
                end
                st_wait: begin
                    if (!tx_busy) begin
                        if (out_idx == last_out) begin
                            state <= st_done;
                        end else begin
                            out_idx <= out_idx + 5'd1;
                            state   <= st_run;
                        end
                    end
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    assign ifmap_addr = out_idx + pe_pkg::ifmap_addr_t'(tap_idx);
    assign filter_addr = tap_idx;
    assign tap_valid = (state == st_run);
    assign acc_clear = tap_valid && (tap_idx == '0);
    assign emit = tap_valid && (tap_idx == last_tap);
    assign round_done = (state == st_done);

    // ready operands count as busy so no packet slips in before the first tap
    assign compute_busy = (state != st_idle) | operands_ready;

endmodule

// ==== design/operand_store.sv ====
`timescale 1ns/1ps

module operand_store (
    input  logic                                         clk,
    input  logic                                         rst,
    input  logic                                         load_ifmap,
    input  logic                                         load_filter,
    input  logic [pe_pkg::ifmap_depth-1:0]               ifmap_bits,
    input  pe_pkg::weight_t [pe_pkg::filter_depth-1:0]   filter_weights,
    input  pe_pkg::ifmap_addr_t                          ifmap_addr,
    input  pe_pkg::filter_addr_t                         filter_addr,
    input  logic                                         round_done,
    output logic                                         operands_ready,
    output logic                                         ifmap_bit,
    output pe_pkg::weight_t                              weight
);

    logic [pe_pkg::ifmap_depth-1:0]             ifmap_q;
    pe_pkg::weight_t [pe_pkg::filter_depth-1:0] weight_q;
    logic                                       ifmap_loaded;
    logic                                       filter_loaded;

    always_ff @(posedge clk) begin
        if (load_ifmap) begin
            ifmap_q <= ifmap_bits;
        end
        if (load_filter) begin
            weight_q <= filter_weights;
        end
    end

    // the filter stays loaded across rounds
    always_ff @(posedge clk) begin
        if (rst) begin
            ifmap_loaded  <= 1'b0;
            filter_loaded <= 1'b0;
        end else begin
            if (round_done) begin
                ifmap_loaded <= 1'b0;
            end
            if (load_ifmap) begin
                ifmap_loaded <= 1'b1;
            end
            if (load_filter) begin
                filter_loaded <= 1'b1;
            end
        end
    end

    assign operands_ready = ifmap_loaded & filter_loaded;
    assign ifmap_bit = ifmap_q[ifmap_addr];
    assign weight = weight_q[filter_addr];

endmodule

// ==== design/packet_rx.sv ====
`timescale 1ns/1ps

module packet_rx (
    input  logic                                         clk,
    input  logic                                         rst,
    input  logic                                         in_cyc,
    input  logic                                         in_stb,
    input  logic                                         in_we,
    input  noc_pkg::noc_packet_t                         in_dat,
    input  logic                                         compute_busy,
    output logic                                         in_ack,
    output logic                                         load_ifmap,
    output logic                                         load_filter,
    output logic [pe_pkg::ifmap_depth-1:0]               ifmap_bits,
    output pe_pkg::weight_t [pe_pkg::filter_depth-1:0]   filter_weights
);

    logic accept;

    // a write cycle is taken only when no ack is pending and the array is idle
    assign accept = in_cyc & in_stb & in_we & ~in_ack & ~compute_busy;

    always_ff @(posedge clk) begin
        if (rst) begin
            in_ack      <= 1'b0;
            load_ifmap  <= 1'b0;
            load_filter <= 1'b0;
        end else begin
            in_ack      <= accept;
            load_ifmap  <= accept & in_dat.header.iff_type;
            load_filter <= accept & ~in_dat.header.iff_type;
        end
    end

    // payload is decoded by the header type, both views are latched together
    always_ff @(posedge clk) begin
        if (accept) begin
            ifmap_bits     <= in_dat.payload.ifmap.bits;
            filter_weights <= in_dat.payload.filter;
        end
    end

endmodule

// ==== design/pe_pkg.sv ====
package pe_pkg;

    // 1-d convolution geometry
    localparam int ifmap_depth = 25;
    localparam int filter_depth = 5;
    localparam int output_count = ifmap_depth - filter_depth + 1;

    typedef logic [7:0] weight_t;

    // five 8-bit weights fit in 11 bits, 13 matches the packet field
    typedef logic [12:0] psum_t;

    typedef logic [4:0] ifmap_addr_t;
    typedef logic [2:0] filter_addr_t;

    typedef struct packed {
        psum_t value;
    } psum_result_t;

endpackage

// ==== design/noc_pkg.sv ====
package noc_pkg;

    localparam int packet_width = 57;
    localparam int header_width = 17;
    localparam int payload_width = packet_width - header_width;
    localparam int ifmap_bits_w = 25;
    localparam int psum_value_w = 13;
    localparam int psum_addr_w = payload_width - psum_value_w;

    typedef logic [3:0] node_id_t;
    typedef logic [2:0] hop_t;

    // iff_type is 1 for ifmap, 0 for filter and psum
    typedef struct packed {
        logic     iff_type;
        node_id_t source;
        node_id_t dest;
        logic     x_dir;
        hop_t     x_hop;
        logic     y_dir;
        hop_t     y_hop;
    } noc_header_t;

    typedef struct packed {
        logic [payload_width-ifmap_bits_w-1:0] pad;
        logic [ifmap_bits_w-1:0]               bits;
    } ifmap_view_t;

    typedef struct packed {
        logic [psum_addr_w-1:0]  addr;
        logic [psum_value_w-1:0] value;
    } psum_view_t;

    // weight 0 sits in the low byte
    typedef union packed {
        ifmap_view_t     ifmap;
        logic [4:0][7:0] filter;
        psum_view_t      psum;
    } noc_payload_u;

    typedef struct packed {
        noc_header_t  header;
        noc_payload_u payload;
    } noc_packet_t;

    localparam node_id_t collector_low = 4'd13;
    localparam node_id_t collector_high = 4'd14;
    localparam int last_low_pe = 5;

endpackage
